/* hdl/shield_bus_pkg.sv */
package shield_bus_pkg;

  localparam int WB_ADR_W = 4;
  localparam int WB_DAT_W = 32;

  // Word address, one register per step
  typedef logic [WB_ADR_W-1:0] wb_adr_t;

  // Data word, only the low byte lane carries SPI bytes
  typedef logic [WB_DAT_W-1:0] wb_dat_t;

  // LCD command port register map
  localparam wb_adr_t ADR_LCD_CMD  = wb_adr_t'(0);  // Byte with data/command low
  localparam wb_adr_t ADR_LCD_DATA = wb_adr_t'(1);  // Byte with data/command high
  localparam wb_adr_t ADR_LCD_CTRL = wb_adr_t'(2);  // Reset release and busy

  // SD transfer port register map
  localparam wb_adr_t ADR_SD_TX   = wb_adr_t'(0);  // Write starts a transfer
  localparam wb_adr_t ADR_SD_RX   = wb_adr_t'(1);  // Last received byte
  localparam wb_adr_t ADR_SD_CTRL = wb_adr_t'(2);  // Select hold and busy

  // Bit positions inside the control registers
  localparam int CTRL_RST_BIT  = 0;
  localparam int CTRL_HOLD_BIT = 0;
  localparam int CTRL_BUSY_BIT = 1;

endpackage

/* hdl/shield_spi_pkg.sv */
package shield_spi_pkg;

  localparam int SPI_BYTE_W = 8;

  // Clock cycles per SCK half period
  localparam int SPI_HALF_PERIOD = 2;

  typedef logic [SPI_BYTE_W-1:0] spi_byte_t;

  typedef logic [$clog2(SPI_BYTE_W)-1:0] bit_cnt_t;
  typedef logic [$clog2(SPI_HALF_PERIOD)-1:0] half_cnt_t;

  // Index of an SPI client on the shared bus
  typedef logic client_t;

  localparam client_t CLIENT_LCD = 1'b0;
  localparam client_t CLIENT_SD  = 1'b1;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_BUSY,
    ARB_LOCKED
  } arb_state_t;

  typedef enum logic [1:0] {
    SH_IDLE,
    SH_SHIFT,
    SH_DONE
  } shift_state_t;

endpackage

/* hdl/spi_link_if.sv */
`timescale 1ns/10ps

interface spi_link_if;

  logic                     req;
  logic                     ack;
  logic                     done;
  shield_spi_pkg::spi_byte_t tx_byte;
  logic                     dc;
  logic                     hold;   // Keep chip select low after this byte
  shield_spi_pkg::spi_byte_t rx_byte;

  modport client (
    output req,
    output tx_byte,
    output dc,
    output hold,
    input  ack,
    input  done,
    input  rx_byte
  );

  modport server (
    input  req,
    input  tx_byte,
    input  dc,
    input  hold,
    output ack,
    output done,
    output rx_byte
  );

endinterface

/* hdl/lcd_cmd_port.sv */
`timescale 1ns/10ps

module lcd_cmd_port (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  shield_bus_pkg::wb_adr_t wb_adr_i,
  input  shield_bus_pkg::wb_dat_t wb_dat_i,
  output shield_bus_pkg::wb_dat_t wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    lcd_rst_n_o,
  spi_link_if.client              link
);

  logic                      ack_q;
  logic                      buf_valid;
  logic                      in_flight;
  logic                      rst_q;
  shield_spi_pkg::spi_byte_t buf_byte;
  logic                      buf_dc;
  logic                      is_byte_adr;
  logic                      can_load;
  logic                      acc;
  logic                      busy;
  shield_bus_pkg::wb_dat_t   rd_data;

  assign is_byte_adr = (wb_adr_i == shield_bus_pkg::ADR_LCD_CMD) ||
                       (wb_adr_i == shield_bus_pkg::ADR_LCD_DATA);
  assign can_load    = !buf_valid || link.ack;  // Buffer frees as the arbiter takes it
  assign acc         = wb_cyc_i && wb_stb_i && !ack_q &&
                       (!wb_we_i || !is_byte_adr || can_load);
  assign busy        = buf_valid || in_flight;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      ack_q     <= 1'b0;
      buf_valid <= 1'b0;
      in_flight <= 1'b0;
      rst_q     <= 1'b0;  // Display stays in reset
    end
    else
    begin
      ack_q <= acc;
      if (link.ack)
      begin
        buf_valid <= 1'b0;
        in_flight <= 1'b1;
      end
      if (link.done)
        in_flight <= 1'b0;
      if (acc && wb_we_i)
      begin
        if (is_byte_adr)
          buf_valid <= 1'b1;
        else if (wb_adr_i == shield_bus_pkg::ADR_LCD_CTRL)
          rst_q <= wb_dat_i[shield_bus_pkg::CTRL_RST_BIT];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (acc && wb_we_i && is_byte_adr)
    begin
      buf_byte <= wb_dat_i[shield_spi_pkg::SPI_BYTE_W-1:0];
      buf_dc   <= (wb_adr_i == shield_bus_pkg::ADR_LCD_DATA);
    end
    if (acc && !wb_we_i)
      wb_dat_o <= rd_data;
  end

  always_comb
  begin
    rd_data = '0;
    if (wb_adr_i == shield_bus_pkg::ADR_LCD_CTRL)
    begin
      rd_data[shield_bus_pkg::CTRL_RST_BIT]  = rst_q;
      rd_data[shield_bus_pkg::CTRL_BUSY_BIT] = busy;
    end
  end

  // A new request waits until the previous byte is done
  assign link.req     = buf_valid && !in_flight;
  assign link.tx_byte = buf_byte;
  assign link.dc      = buf_dc;
  assign link.hold    = 1'b0;

  assign wb_ack_o    = ack_q;
  assign lcd_rst_n_o = rst_q;

endmodule

/* hdl/sd_xfer_port.sv */
`timescale 1ns/10ps

module sd_xfer_port (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  shield_bus_pkg::wb_adr_t wb_adr_i,
  input  shield_bus_pkg::wb_dat_t wb_dat_i,
  output shield_bus_pkg::wb_dat_t wb_dat_o,
  output logic                    wb_ack_o,
  spi_link_if.client              link
);

  logic                      ack_q;
  logic                      req_q;
  logic                      in_flight;
  logic                      hold_q;
  shield_spi_pkg::spi_byte_t tx_q;
  shield_spi_pkg::spi_byte_t rx_q;
  logic                      is_tx_adr;
  logic                      acc;
  logic                      busy;
  shield_bus_pkg::wb_dat_t   rd_data;

  assign is_tx_adr = (wb_adr_i == shield_bus_pkg::ADR_SD_TX);
  assign busy      = req_q || in_flight;
  assign acc       = wb_cyc_i && wb_stb_i && !ack_q &&
                     (!wb_we_i || !is_tx_adr || !busy);  // TX stalls until done

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      ack_q     <= 1'b0;
      req_q     <= 1'b0;
      in_flight <= 1'b0;
      hold_q    <= 1'b0;
    end
    else
    begin
      ack_q <= acc;
      if (link.ack)
      begin
        req_q     <= 1'b0;
        in_flight <= 1'b1;
      end
      if (link.done)
        in_flight <= 1'b0;
      if (acc && wb_we_i)
      begin
        if (is_tx_adr)
          req_q <= 1'b1;
        else if (wb_adr_i == shield_bus_pkg::ADR_SD_CTRL)
          hold_q <= wb_dat_i[shield_bus_pkg::CTRL_HOLD_BIT];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (acc && wb_we_i && is_tx_adr)
      tx_q <= wb_dat_i[shield_spi_pkg::SPI_BYTE_W-1:0];
    if (link.done)
      rx_q <= link.rx_byte;
    if (acc && !wb_we_i)
      wb_dat_o <= rd_data;
  end

  always_comb
  begin
    rd_data = '0;
    case (wb_adr_i)
      shield_bus_pkg::ADR_SD_RX:
        rd_data[shield_spi_pkg::SPI_BYTE_W-1:0] = rx_q;
      shield_bus_pkg::ADR_SD_CTRL:
      begin
        rd_data[shield_bus_pkg::CTRL_HOLD_BIT] = hold_q;
        rd_data[shield_bus_pkg::CTRL_BUSY_BIT] = busy;
      end
      default:
        rd_data = '0;
    endcase
  end

  assign link.req     = req_q;
  assign link.tx_byte = tx_q;
  assign link.dc      = 1'b0;
  assign link.hold    = hold_q;  // Clearing it also releases a held select

  assign wb_ack_o = ack_q;

endmodule

/* hdl/spi_arb.sv */
`timescale 1ns/10ps

module spi_arb (
  input  logic        clk,
  input  logic        rst_n_i,
  spi_link_if.server  lcd,
  spi_link_if.server  sd,
  spi_link_if.client  shift,
  output logic        lcd_cs_n_o,
  output logic        sd_cs_n_o,
  output logic        lcd_dc_o
);

  shield_spi_pkg::arb_state_t state;
  shield_spi_pkg::client_t    grant_q;
  shield_spi_pkg::client_t    pick;
  shield_spi_pkg::spi_byte_t  tx_q;
  logic                       lcd_ack_q;
  logic                       sd_ack_q;
  logic                       shift_req_q;
  logic                       lcd_cs_n_q;
  logic                       sd_cs_n_q;
  logic                       dc_q;
  logic                       hold_q;
  logic                       lock_req;
  logic                       lock_hold;
  logic                       grant_en;

  assign lock_req  = (grant_q == shield_spi_pkg::CLIENT_SD) ? sd.req  : lcd.req;
  assign lock_hold = (grant_q == shield_spi_pkg::CLIENT_SD) ? sd.hold : lcd.hold;
  assign grant_en  = ((state == shield_spi_pkg::ARB_IDLE) && (lcd.req || sd.req)) ||
                     ((state == shield_spi_pkg::ARB_LOCKED) && lock_req);

  always_comb
  begin
    if (state == shield_spi_pkg::ARB_LOCKED)
      pick = grant_q;
    else if (lcd.req && sd.req)
      pick = ~grant_q;  // Alternate when both wait
    else if (sd.req)
      pick = shield_spi_pkg::CLIENT_SD;
    else
      pick = shield_spi_pkg::CLIENT_LCD;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state       <= shield_spi_pkg::ARB_IDLE;
      grant_q     <= shield_spi_pkg::CLIENT_LCD;
      lcd_ack_q   <= 1'b0;
      sd_ack_q    <= 1'b0;
      shift_req_q <= 1'b0;
      lcd_cs_n_q  <= 1'b1;
      sd_cs_n_q   <= 1'b1;
      dc_q        <= 1'b0;
      hold_q      <= 1'b0;
    end
    else
    begin
      lcd_ack_q <= 1'b0;
      sd_ack_q  <= 1'b0;
      if (shift.ack)
        shift_req_q <= 1'b0;
      if (grant_en)
      begin
        state       <= shield_spi_pkg::ARB_BUSY;
        grant_q     <= pick;
        shift_req_q <= 1'b1;
        if (pick == shield_spi_pkg::CLIENT_SD)
        begin
          sd_ack_q  <= 1'b1;
          sd_cs_n_q <= 1'b0;
          hold_q    <= sd.hold;
        end
        else
        begin
          lcd_ack_q  <= 1'b1;
          lcd_cs_n_q <= 1'b0;
          hold_q     <= lcd.hold;
          dc_q       <= lcd.dc;
        end
      end
      else if ((state == shield_spi_pkg::ARB_BUSY) && shift.done)
      begin
        if (hold_q)
          state <= shield_spi_pkg::ARB_LOCKED;  // Select stays low
        else
        begin
          state      <= shield_spi_pkg::ARB_IDLE;
          lcd_cs_n_q <= 1'b1;
          sd_cs_n_q  <= 1'b1;
        end
      end
      else if ((state == shield_spi_pkg::ARB_LOCKED) && !lock_hold)
      begin
        state      <= shield_spi_pkg::ARB_IDLE;
        lcd_cs_n_q <= 1'b1;
        sd_cs_n_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (grant_en)
      tx_q <= (pick == shield_spi_pkg::CLIENT_SD) ? sd.tx_byte : lcd.tx_byte;
  end

  assign shift.req     = shift_req_q;
  assign shift.tx_byte = tx_q;
  assign shift.dc      = dc_q;
  assign shift.hold    = hold_q;

  assign lcd.ack     = lcd_ack_q;
  assign sd.ack      = sd_ack_q;
  assign lcd.done    = shift.done && (grant_q == shield_spi_pkg::CLIENT_LCD);
  assign sd.done     = shift.done && (grant_q == shield_spi_pkg::CLIENT_SD);
  assign lcd.rx_byte = (grant_q == shield_spi_pkg::CLIENT_LCD) ? shift.rx_byte : '0;
  assign sd.rx_byte  = (grant_q == shield_spi_pkg::CLIENT_SD)  ? shift.rx_byte : '0;

  assign lcd_cs_n_o = lcd_cs_n_q;
  assign sd_cs_n_o  = sd_cs_n_q;
  assign lcd_dc_o   = dc_q;

endmodule

/* hdl/spi_shifter.sv */
`timescale 1ns/10ps

module spi_shifter (
  input  logic       clk,
  input  logic       rst_n_i,
  spi_link_if.server link,
  output logic       sclk_o,
  output logic       mosi_o,
  input  logic       miso_i
);

  shield_spi_pkg::shift_state_t state;
  shield_spi_pkg::half_cnt_t    half_cnt;
  shield_spi_pkg::bit_cnt_t     bit_cnt;
  shield_spi_pkg::spi_byte_t    tx_sr;
  shield_spi_pkg::spi_byte_t    rx_sr;
  logic                         sclk_q;
  logic                         phase_end;
  logic                         last_bit;

  assign phase_end = (state == shield_spi_pkg::SH_SHIFT) &&
                     (half_cnt == shield_spi_pkg::half_cnt_t'(shield_spi_pkg::SPI_HALF_PERIOD - 1));
  assign last_bit  = (bit_cnt == shield_spi_pkg::bit_cnt_t'(shield_spi_pkg::SPI_BYTE_W - 1));

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state    <= shield_spi_pkg::SH_IDLE;
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk_q   <= 1'b0;
    end
    else
    begin
      case (state)
        shield_spi_pkg::SH_IDLE:
          if (link.req)
          begin
            state    <= shield_spi_pkg::SH_SHIFT;
            half_cnt <= '0;
            bit_cnt  <= '0;
          end
        shield_spi_pkg::SH_SHIFT:
          if (phase_end)
          begin
            half_cnt <= '0;
            sclk_q   <= ~sclk_q;
            if (sclk_q && last_bit)
              state <= shield_spi_pkg::SH_DONE;  // Eighth falling edge
            else if (sclk_q)
              bit_cnt <= bit_cnt + 1'b1;
          end
          else
            half_cnt <= half_cnt + 1'b1;
        shield_spi_pkg::SH_DONE:
          state <= shield_spi_pkg::SH_IDLE;
        default:
          state <= shield_spi_pkg::SH_IDLE;
      endcase
    end
  end

  // MSB first; MOSI moves on the falling edge, MISO is taken on the rising edge
  always_ff @(posedge clk)
  begin
    if (link.ack)
      tx_sr <= link.tx_byte;
    else if (phase_end && sclk_q)
      tx_sr <= {tx_sr[shield_spi_pkg::SPI_BYTE_W-2:0], 1'b0};
    if (phase_end && !sclk_q)
      rx_sr <= {rx_sr[shield_spi_pkg::SPI_BYTE_W-2:0], miso_i};
  end

  assign link.ack     = link.req && (state == shield_spi_pkg::SH_IDLE);
  assign link.done    = (state == shield_spi_pkg::SH_DONE);
  assign link.rx_byte = rx_sr;

  assign sclk_o = sclk_q;
  assign mosi_o = tx_sr[shield_spi_pkg::SPI_BYTE_W-1];

endmodule

/* hdl/tft_touch_shield.sv */
`timescale 1ns/10ps

module tft_touch_shield (
  input  logic                    clk,
  input  logic                    rst_n_i,

  input  logic                    lcd_cyc_i,
  input  logic                    lcd_stb_i,
  input  logic                    lcd_we_i,
  input  shield_bus_pkg::wb_adr_t lcd_adr_i,
  input  shield_bus_pkg::wb_dat_t lcd_dat_i,
  output shield_bus_pkg::wb_dat_t lcd_dat_o,
  output logic                    lcd_ack_o,

  input  logic                    sd_cyc_i,
  input  logic                    sd_stb_i,
  input  logic                    sd_we_i,
  input  shield_bus_pkg::wb_adr_t sd_adr_i,
  input  shield_bus_pkg::wb_dat_t sd_dat_i,
  output shield_bus_pkg::wb_dat_t sd_dat_o,
  output logic                    sd_ack_o,

  output logic                    sclk_o,
  output logic                    mosi_o,
  input  logic                    miso_i,
  output logic                    lcd_cs_n_o,
  output logic                    sd_cs_n_o,
  output logic                    lcd_dc_o,
  output logic                    lcd_rst_n_o,
  output logic                    tp_cs_n_o
);

  spi_link_if lcd_link ();
  spi_link_if sd_link ();
  spi_link_if shift_link ();

  assign tp_cs_n_o = 1'b1;  // Touch controller stays deselected

  lcd_cmd_port lcd_port (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .wb_cyc_i    (lcd_cyc_i),
    .wb_stb_i    (lcd_stb_i),
    .wb_we_i     (lcd_we_i),
    .wb_adr_i    (lcd_adr_i),
    .wb_dat_i    (lcd_dat_i),
    .wb_dat_o    (lcd_dat_o),
    .wb_ack_o    (lcd_ack_o),
    .lcd_rst_n_o (lcd_rst_n_o),
    .link        (lcd_link.client)
  );

  sd_xfer_port sd_port (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (sd_cyc_i),
    .wb_stb_i (sd_stb_i),
    .wb_we_i  (sd_we_i),
    .wb_adr_i (sd_adr_i),
    .wb_dat_i (sd_dat_i),
    .wb_dat_o (sd_dat_o),
    .wb_ack_o (sd_ack_o),
    .link     (sd_link.client)
  );

  spi_arb arb (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .lcd        (lcd_link.server),
    .sd         (sd_link.server),
    .shift      (shift_link.client),
    .lcd_cs_n_o (lcd_cs_n_o),
    .sd_cs_n_o  (sd_cs_n_o),
    .lcd_dc_o   (lcd_dc_o)
  );

  spi_shifter shifter (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .link    (shift_link.server),
    .sclk_o  (sclk_o),
    .mosi_o  (mosi_o),
    .miso_i  (miso_i)
  );

endmodule

/* sim/shield_checker.sv */
`timescale 1ns/10ps

module shield_checker (
  input logic clk,
  input logic rst_n_i,
  input logic lcd_cyc_i,
  input logic lcd_stb_i,
  input logic lcd_ack_i,
  input logic sd_cyc_i,
  input logic sd_stb_i,
  input logic sd_ack_i,
  input logic sclk_i,
  input logic lcd_cs_n_i,
  input logic sd_cs_n_i
);

  cs_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(!lcd_cs_n_i && !sd_cs_n_i))
    else $error("LCD and SD chip selects are low together");

  // SCK may only toggle while a device is selected
  sclk_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
    (lcd_cs_n_i && sd_cs_n_i) |-> !sclk_i)
    else $error("SCK is high while no chip select is low");

  lcd_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    lcd_ack_i |-> (lcd_cyc_i && lcd_stb_i))
    else $error("LCD port ack outside a bus cycle");

  sd_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    sd_ack_i |-> (sd_cyc_i && sd_stb_i))
    else $error("SD port ack outside a bus cycle");

endmodule

bind tft_touch_shield shield_checker shield_chk (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .lcd_cyc_i  (lcd_cyc_i),
  .lcd_stb_i  (lcd_stb_i),
  .lcd_ack_i  (lcd_ack_o),
  .sd_cyc_i   (sd_cyc_i),
  .sd_stb_i   (sd_stb_i),
  .sd_ack_i   (sd_ack_o),
  .sclk_i     (sclk_o),
  .lcd_cs_n_i (lcd_cs_n_o),
  .sd_cs_n_i  (sd_cs_n_o)
);

/* sim/tb_shield.sv */
`timescale 1ns/10ps

module tb_shield;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int BYTE_CYCLES  = 2 * shield_spi_pkg::SPI_HALF_PERIOD * 8 + 8;  // With handshakes
  localparam int TEST_BYTES   = 14;
  localparam int TIMEOUT_NS   = 20 * TEST_BYTES * BYTE_CYCLES * CLK_PERIOD;
  localparam bit PORT_LCD     = 1'b0;
  localparam bit PORT_SD      = 1'b1;

  logic                    clk;
  logic                    rst_n;
  logic                    lcd_cyc;
  logic                    lcd_stb;
  logic                    lcd_we;
  shield_bus_pkg::wb_adr_t lcd_adr;
  shield_bus_pkg::wb_dat_t lcd_dat_w;
  shield_bus_pkg::wb_dat_t lcd_dat_r;
  logic                    lcd_ack;
  logic                    sd_cyc;
  logic                    sd_stb;
  logic                    sd_we;
  shield_bus_pkg::wb_adr_t sd_adr;
  shield_bus_pkg::wb_dat_t sd_dat_w;
  shield_bus_pkg::wb_dat_t sd_dat_r;
  logic                    sd_ack;
  logic                    sclk;
  logic                    mosi;
  logic                    miso;
  logic                    lcd_cs_n;
  logic                    sd_cs_n;
  logic                    lcd_dc;
  logic                    lcd_rst_n;
  logic                    tp_cs_n;

  logic [7:0]  cap_byte_q[$];
  logic        cap_sel_q[$];   // Set when the byte went out on the SD select
  logic        cap_dc_q[$];
  logic [7:0]  cap_resp_q[$];
  logic [7:0]  mosi_sr;
  logic [7:0]  resp_byte;
  logic [7:0]  miso_bits;
  logic        sclk_prev;
  logic        sd_cs_prev;
  int          bit_cnt;
  int          sd_release_cnt;
  int          error_cnt;
  int          check_cnt;

  tft_touch_shield DUT (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .lcd_cyc_i   (lcd_cyc),
    .lcd_stb_i   (lcd_stb),
    .lcd_we_i    (lcd_we),
    .lcd_adr_i   (lcd_adr),
    .lcd_dat_i   (lcd_dat_w),
    .lcd_dat_o   (lcd_dat_r),
    .lcd_ack_o   (lcd_ack),
    .sd_cyc_i    (sd_cyc),
    .sd_stb_i    (sd_stb),
    .sd_we_i     (sd_we),
    .sd_adr_i    (sd_adr),
    .sd_dat_i    (sd_dat_w),
    .sd_dat_o    (sd_dat_r),
    .sd_ack_o    (sd_ack),
    .sclk_o      (sclk),
    .mosi_o      (mosi),
    .miso_i      (miso),
    .lcd_cs_n_o  (lcd_cs_n),
    .sd_cs_n_o   (sd_cs_n),
    .lcd_dc_o    (lcd_dc),
    .lcd_rst_n_o (lcd_rst_n),
    .tp_cs_n_o   (tp_cs_n)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // SPI device model that samples SCK edges on the falling clk edge and answers with random bytes
  initial
  begin : spi_device
    void'($urandom(32'h9b07_1d89));
    miso           = 1'b0;
    bit_cnt        = 0;
    mosi_sr        = '0;
    sclk_prev      = 1'b0;
    sd_cs_prev     = 1'b1;
    sd_release_cnt = 0;
    @(posedge rst_n);
    resp_byte = 8'($urandom);
    miso      = resp_byte[7];
    forever
    begin
      @(negedge clk);
      if (sclk && !sclk_prev && (!lcd_cs_n || !sd_cs_n))
      begin
        mosi_sr = {mosi_sr[6:0], mosi};
        bit_cnt = bit_cnt + 1;
        if (bit_cnt == 8)
        begin
          cap_byte_q.push_back(mosi_sr);
          cap_sel_q.push_back(!sd_cs_n);
          cap_dc_q.push_back(lcd_dc);
          cap_resp_q.push_back(resp_byte);
          resp_byte = 8'($urandom);
          bit_cnt   = 0;
        end
      end
      if (!sclk && sclk_prev)
      begin
        miso_bits = resp_byte << bit_cnt;
        miso      = miso_bits[7];  // Next bit after each falling edge
      end
      if (sd_cs_n && !sd_cs_prev)
        sd_release_cnt = sd_release_cnt + 1;
      sclk_prev  = sclk;
      sd_cs_prev = sd_cs_n;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt = check_cnt + 1;
    if (expected !== actual)
    begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      error_cnt = error_cnt + 1;
    end
  endtask

  task automatic drive_bus(input bit port, input logic cyc, input logic we,
                           input shield_bus_pkg::wb_adr_t adr,
                           input shield_bus_pkg::wb_dat_t dat);
    if (port == PORT_LCD)
    begin
      lcd_cyc   = cyc;
      lcd_stb   = cyc;
      lcd_we    = we;
      lcd_adr   = adr;
      lcd_dat_w = dat;
    end
    else
    begin
      sd_cyc   = cyc;
      sd_stb   = cyc;
      sd_we    = we;
      sd_adr   = adr;
      sd_dat_w = dat;
    end
  endtask

  // One Wishbone access that holds the cycle through the edge which sees ack
  task automatic bus_cycle(input bit port, input logic we, input shield_bus_pkg::wb_adr_t adr,
                           input shield_bus_pkg::wb_dat_t wdat,
                           output shield_bus_pkg::wb_dat_t rdat);
    logic ack_seen;
    ack_seen = 1'b0;
    @(negedge clk);
    drive_bus(port, 1'b1, we, adr, wdat);
    while (!ack_seen)
    begin
      @(negedge clk);
      ack_seen = (port == PORT_LCD) ? lcd_ack : sd_ack;
    end
    rdat = (port == PORT_LCD) ? lcd_dat_r : sd_dat_r;
    @(negedge clk);
    drive_bus(port, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic wb_write(input bit port, input shield_bus_pkg::wb_adr_t adr,
                          input logic [7:0] data);
    shield_bus_pkg::wb_dat_t unused_rd;
    bus_cycle(port, 1'b1, adr, 32'(data), unused_rd);
  endtask

  task automatic wb_read(input bit port, input shield_bus_pkg::wb_adr_t adr,
                         output shield_bus_pkg::wb_dat_t data);
    bus_cycle(port, 1'b0, adr, '0, data);
  endtask

  task automatic wait_port_idle(input bit port);
    shield_bus_pkg::wb_adr_t adr;
    shield_bus_pkg::wb_dat_t ctrl;
    adr  = (port == PORT_LCD) ? shield_bus_pkg::ADR_LCD_CTRL : shield_bus_pkg::ADR_SD_CTRL;
    ctrl = '1;
    while (ctrl[shield_bus_pkg::CTRL_BUSY_BIT])
      wb_read(port, adr, ctrl);
  endtask

  task automatic wait_bytes(input int count);
    while (cap_byte_q.size() < count)
      @(negedge clk);
  endtask

  task automatic check_byte(input string name, input int idx, input logic [7:0] value,
                            input bit sel);
    check_value({name, " byte"}, 32'(value), 32'(cap_byte_q[idx]));
    check_value({name, " select"}, 32'(sel), 32'(cap_sel_q[idx]));
  endtask

  task automatic test_reset_state();
    shield_bus_pkg::wb_dat_t rd;
    check_value("reset sclk", 0, 32'(sclk));
    check_value("reset lcd_cs_n", 1, 32'(lcd_cs_n));
    check_value("reset sd_cs_n", 1, 32'(sd_cs_n));
    check_value("reset lcd_rst_n", 0, 32'(lcd_rst_n));
    check_value("reset lcd_ack", 0, 32'(lcd_ack));
    check_value("reset sd_ack", 0, 32'(sd_ack));
    check_value("reset tp_cs_n", 1, 32'(tp_cs_n));
    wb_write(PORT_LCD, shield_bus_pkg::ADR_LCD_CTRL, 8'h01);
    check_value("reset release lcd_rst_n", 1, 32'(lcd_rst_n));
    wb_read(PORT_LCD, shield_bus_pkg::ADR_LCD_CTRL, rd);
    check_value("reset ctrl readback", 32'h1, rd);
  endtask

  task automatic test_lcd_cmd_data();
    int base;
    base = cap_byte_q.size();
    wb_write(PORT_LCD, shield_bus_pkg::ADR_LCD_CMD, 8'h2A);
    wb_write(PORT_LCD, shield_bus_pkg::ADR_LCD_DATA, 8'h5C);
    wait_bytes(base + 2);
    wait_port_idle(PORT_LCD);
    check_byte("lcd_cmd_data first", base, 8'h2A, PORT_LCD);
    check_value("lcd_cmd_data first dc", 0, 32'(cap_dc_q[base]));
    check_byte("lcd_cmd_data second", base + 1, 8'h5C, PORT_LCD);
    check_value("lcd_cmd_data second dc", 1, 32'(cap_dc_q[base + 1]));
  endtask

  task automatic test_sd_transfer();
    int                      base;
    shield_bus_pkg::wb_dat_t rd;
    base = cap_byte_q.size();
    wb_write(PORT_SD, shield_bus_pkg::ADR_SD_TX, 8'hA7);
    wait_bytes(base + 1);
    wait_port_idle(PORT_SD);
    check_byte("sd_transfer", base, 8'hA7, PORT_SD);
    wb_read(PORT_SD, shield_bus_pkg::ADR_SD_RX, rd);
    check_value("sd_transfer rx", 32'(cap_resp_q[base]), rd);
  endtask

  task automatic test_lcd_burst();
    int                      base;
    int                      i;
    shield_bus_pkg::wb_dat_t rd;
    base = cap_byte_q.size();
    for (i = 0; i < 5; i++)
      wb_write(PORT_LCD, shield_bus_pkg::ADR_LCD_DATA, 8'(8'h30 + 8'h11 * i));
    wait_bytes(base + 5);
    wait_port_idle(PORT_LCD);
    for (i = 0; i < 5; i++)
    begin
      check_byte("lcd_burst", base + i, 8'(8'h30 + 8'h11 * i), PORT_LCD);
      check_value("lcd_burst dc", 1, 32'(cap_dc_q[base + i]));
    end
    wb_read(PORT_LCD, shield_bus_pkg::ADR_LCD_CTRL, rd);
    check_value("lcd_burst ctrl idle", 32'h1, rd);  // Reset released and not busy
  endtask

  task automatic test_sd_hold();
    int base;
    int releases;
    base     = cap_byte_q.size();
    releases = sd_release_cnt;
    wb_write(PORT_SD, shield_bus_pkg::ADR_SD_CTRL, 8'h01);
    wb_write(PORT_SD, shield_bus_pkg::ADR_SD_TX, 8'hE1);
    wb_write(PORT_LCD, shield_bus_pkg::ADR_LCD_DATA, 8'h6B);
    wb_write(PORT_SD, shield_bus_pkg::ADR_SD_TX, 8'hE2);
    wb_write(PORT_SD, shield_bus_pkg::ADR_SD_TX, 8'hE3);
    wait_bytes(base + 3);
    wait_port_idle(PORT_SD);
    check_value("sd_hold lcd still waiting", base + 3, cap_byte_q.size());
    check_value("sd_hold select low", 0, 32'(sd_cs_n));
    check_value("sd_hold select releases", releases, sd_release_cnt);
    wb_write(PORT_SD, shield_bus_pkg::ADR_SD_CTRL, 8'h00);
    wait_bytes(base + 4);
    wait_port_idle(PORT_LCD);
    check_byte("sd_hold first", base, 8'hE1, PORT_SD);
    check_byte("sd_hold second", base + 1, 8'hE2, PORT_SD);
    check_byte("sd_hold third", base + 2, 8'hE3, PORT_SD);
    check_byte("sd_hold lcd", base + 3, 8'h6B, PORT_LCD);
    check_value("sd_hold single release", releases + 1, sd_release_cnt);
  endtask

  task automatic test_same_cycle();
    int base;
    int i;
    int lcd_seen;
    int sd_seen;
    base     = cap_byte_q.size();
    lcd_seen = 0;
    sd_seen  = 0;
    fork
      wb_write(PORT_LCD, shield_bus_pkg::ADR_LCD_DATA, 8'h3C);
      wb_write(PORT_SD, shield_bus_pkg::ADR_SD_TX, 8'hC3);
    join
    wait_bytes(base + 2);
    wait_port_idle(PORT_LCD);
    wait_port_idle(PORT_SD);
    for (i = base; i < base + 2; i++)
    begin
      if (cap_sel_q[i] == PORT_LCD)
      begin
        check_value("same_cycle lcd byte", 32'h3C, 32'(cap_byte_q[i]));
        lcd_seen = lcd_seen + 1;
      end
      else
      begin
        check_value("same_cycle sd byte", 32'hC3, 32'(cap_byte_q[i]));
        sd_seen = sd_seen + 1;
      end
    end
    check_value("same_cycle lcd count", 1, lcd_seen);
    check_value("same_cycle sd count", 1, sd_seen);
  endtask

  initial
  begin
    error_cnt = 0;
    check_cnt = 0;
    rst_n     = 1'b0;
    drive_bus(PORT_LCD, 1'b0, 1'b0, '0, '0);
    drive_bus(PORT_SD, 1'b0, 1'b0, '0, '0);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_state();
    test_lcd_cmd_data();
    test_sd_transfer();
    test_lcd_burst();
    test_sd_hold();
    test_same_cycle();
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

endmodule

/* build.f */
hdl/shield_bus_pkg.sv
hdl/shield_spi_pkg.sv
hdl/spi_link_if.sv
hdl/lcd_cmd_port.sv
hdl/sd_xfer_port.sv
hdl/spi_arb.sv
hdl/spi_shifter.sv
hdl/tft_touch_shield.sv
sim/shield_checker.sv
sim/tb_shield.sv

/* Makefile */
# Verilator build and run for the shield SPI controller

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module tb_shield -f build.f

# The run passes only if the testbench prints the pass message
run: build
	@out="$$(./obj_dir/Vtb_shield)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing -Wall --top-module tb_shield -f build.f

clean:
	rm -rf obj_dir
